/* src/rob_pkg.sv */
// Reorder buffer package with payload field widths shared by all blocks
package rob_pkg;

   // Program counter and register address widths
   localparam int PC_W   = 32;
   localparam int LRF_AW = 5;
   localparam int PRF_AW = 6;

   // Operand value width
   localparam int DW     = 32;

   // Packed entry {pc, lrd, prd, prd_we, pfree}
   localparam int PAYLOAD_W = PC_W + LRF_AW + PRF_AW + 1 + PRF_AW;

endpackage

/* src/rob_bank.sv */
// Reorder buffer bank holding a FIFO of payloads with completion tags and operands
module rob_bank #(
   parameter int P_DEPTH = 2
) (
   input  logic                         clk,
   input  logic                         arst_n,
   input  logic                         flush,
   input  logic                         bank_push,
   input  logic [rob_pkg::PAYLOAD_W-1:0] bank_din,
   input  logic                         bank_pop,
   input  logic                         bank_wb,
   input  logic [P_DEPTH-1:0]           bank_wb_id,
   input  logic                         bank_wb_fls,
   input  logic                         bank_wb_exc,
   input  logic [2*rob_pkg::DW-1:0]     bank_wb_val,
   output logic                         bank_valid,
   output logic                         bank_ready,
   output logic [P_DEPTH-1:0]           bank_wptr,
   output logic [rob_pkg::PAYLOAD_W-1:0] head_payload,
   output logic                         head_done,
   output logic                         head_fls,
   output logic                         head_exc,
   output logic [2*rob_pkg::DW-1:0]     head_val
);
   import rob_pkg::*;

   localparam int DEPTH = 1 << P_DEPTH;

   logic [P_DEPTH-1:0]   rptr;
   logic [P_DEPTH-1:0]   wptr;
   logic [P_DEPTH:0]     count;
   logic [PAYLOAD_W-1:0] payload_mem [DEPTH];
   logic [2*DW-1:0]      val_mem [DEPTH];
   logic [DEPTH-1:0]     done_q;
   logic [DEPTH-1:0]     fls_q;
   logic [DEPTH-1:0]     exc_q;
   logic                 do_push;
   logic                 do_pop;
   logic                 do_wb;
   logic [P_DEPTH-1:0]   wb_off;

   // Flush wins over everything in the same cycle
   assign do_push = bank_push & ~flush;
   assign do_pop  = bank_pop & ~flush;
   assign do_wb   = bank_wb & ~flush;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         rptr  <= '0;
         wptr  <= '0;
         count <= '0;
      end
      else if (flush)
      begin
         rptr  <= '0;
         wptr  <= '0;
         count <= '0;
      end
      else
      begin
         if (do_push)
            wptr <= wptr + 1'b1;
         if (do_pop)
            rptr <= rptr + 1'b1;
         if (do_push && !do_pop)
            count <= count + 1'b1;
         else if (do_pop && !do_push)
            count <= count - 1'b1;
      end
   end

   // Completion tags, cleared on push and set on writeback
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
      begin
         done_q <= '0;
         fls_q  <= '0;
         exc_q  <= '0;
      end
      else if (flush)
      begin
         done_q <= '0;
         fls_q  <= '0;
         exc_q  <= '0;
      end
      else
      begin
         if (do_push)
         begin
            done_q[wptr] <= 1'b0;
            fls_q[wptr]  <= 1'b0;
            exc_q[wptr]  <= 1'b0;
         end
         if (do_wb)
         begin
            done_q[bank_wb_id] <= 1'b1;
            fls_q[bank_wb_id]  <= bank_wb_fls;
            exc_q[bank_wb_id]  <= bank_wb_exc;
         end
      end
   end

   always_ff @(posedge clk)
   begin
      if (do_push)
         payload_mem[wptr] <= bank_din;
      if (do_wb)
         val_mem[bank_wb_id] <= bank_wb_val;
   end

   assign bank_valid   = (count != '0);
   assign bank_ready   = (count != DEPTH[P_DEPTH:0]);
   assign bank_wptr    = wptr;
   // Head is read without a clock
   assign head_payload = payload_mem[rptr];
   assign head_val     = val_mem[rptr];
   assign head_done    = done_q[rptr];
   assign head_fls     = fls_q[rptr];
   assign head_exc     = exc_q[rptr];

   // Distance of the writeback target from the head
   assign wb_off = bank_wb_id - rptr;

   a_pop_empty: assert property (@(posedge clk) disable iff (!arst_n)
      do_pop |-> bank_valid);
   a_push_full: assert property (@(posedge clk) disable iff (!arst_n)
      (do_push && !do_pop) |-> bank_ready);
   a_wb_unused: assert property (@(posedge clk) disable iff (!arst_n)
      do_wb |-> ({1'b0, wb_off} < count));

endmodule

/* src/rob_dispatch.sv */
// Issue side of the reorder buffer, tail pointer and slot rotation onto banks
module rob_dispatch #(
   parameter int P_BANKS = 1,
   parameter int P_DEPTH = 2
) (
   input  logic                                   clk,
   input  logic                                   arst_n,
   input  logic                                   flush,
   input  logic [P_BANKS:0]                       push_size,
   input  logic [(1<<P_BANKS)*rob_pkg::PC_W-1:0]   push_pc,
   input  logic [(1<<P_BANKS)*rob_pkg::LRF_AW-1:0] push_lrd,
   input  logic [(1<<P_BANKS)*rob_pkg::PRF_AW-1:0] push_prd,
   input  logic [(1<<P_BANKS)-1:0]                push_prd_we,
   input  logic [(1<<P_BANKS)*rob_pkg::PRF_AW-1:0] push_pfree,
   input  logic [(1<<P_BANKS)*P_DEPTH-1:0]        bank_wptr_all,
   input  logic [(1<<P_BANKS)-1:0]                bank_ready_all,
   output logic                                   rob_ready,
   output logic [(1<<P_BANKS)*P_DEPTH-1:0]        rob_free_id,
   output logic [(1<<P_BANKS)*P_BANKS-1:0]        rob_free_bank,
   output logic [(1<<P_BANKS)-1:0]                bank_push_all,
   output logic [(1<<P_BANKS)*rob_pkg::PAYLOAD_W-1:0] bank_din_all
);
   import rob_pkg::*;

   localparam int BANKS = 1 << P_BANKS;

   logic [P_BANKS-1:0]   tail_q;
   logic [PAYLOAD_W-1:0] slot_din [BANKS];

   // Tail moves by push_size modulo the bank count
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         tail_q <= '0;
      else if (flush)
         tail_q <= '0;
      else
         tail_q <= tail_q + push_size[P_BANKS-1:0];
   end

   for (genvar i = 0; i < BANKS; i++)
   begin : g_slot
      logic [P_BANKS-1:0] off;
      logic [P_BANKS-1:0] fbank;

      assign slot_din[i] = {push_pc[i*PC_W +: PC_W],
                            push_lrd[i*LRF_AW +: LRF_AW],
                            push_prd[i*PRF_AW +: PRF_AW],
                            push_prd_we[i],
                            push_pfree[i*PRF_AW +: PRF_AW]};

      // Bank i takes the slot at its distance from the tail
      assign off = P_BANKS'(i) - tail_q;
      assign bank_push_all[i] = ({1'b0, off} < push_size);
      assign bank_din_all[i*PAYLOAD_W +: PAYLOAD_W] = slot_din[off];

      // Where slot i would land
      assign fbank = tail_q + P_BANKS'(i);
      assign rob_free_bank[i*P_BANKS +: P_BANKS] = fbank;
      assign rob_free_id[i*P_DEPTH +: P_DEPTH] = bank_wptr_all[fbank*P_DEPTH +: P_DEPTH];
   end

   // One full bank stalls the whole issue group
   assign rob_ready = &bank_ready_all;

   a_push_stall: assert property (@(posedge clk) disable iff (!arst_n)
      (push_size != '0) |-> rob_ready);

endmodule

/* src/rob_wb_route.sv */
// Writeback router steering each port onto the bank it names
module rob_wb_route #(
   parameter int P_BANKS = 1,
   parameter int P_DEPTH = 2,
   parameter int P_WB    = 1
) (
   input  logic                                  clk,
   input  logic [(1<<P_WB)-1:0]                  wb_valid,
   input  logic [(1<<P_WB)*P_BANKS-1:0]          wb_rob_bank,
   input  logic [(1<<P_WB)*P_DEPTH-1:0]          wb_rob_id,
   input  logic [(1<<P_WB)-1:0]                  wb_fls,
   input  logic [(1<<P_WB)-1:0]                  wb_exc,
   input  logic [(1<<P_WB)*rob_pkg::DW-1:0]      wb_opera,
   input  logic [(1<<P_WB)*rob_pkg::DW-1:0]      wb_operb,
   output logic [(1<<P_BANKS)-1:0]               bank_wb_all,
   output logic [(1<<P_BANKS)*P_DEPTH-1:0]       bank_wb_id_all,
   output logic [(1<<P_BANKS)-1:0]               bank_wb_fls_all,
   output logic [(1<<P_BANKS)-1:0]               bank_wb_exc_all,
   output logic [(1<<P_BANKS)*2*rob_pkg::DW-1:0] bank_wb_val_all
);
   import rob_pkg::*;

   localparam int BANKS = 1 << P_BANKS;
   localparam int WB    = 1 << P_WB;

   logic [WB-1:0] hit [BANKS];

   always_comb
   begin
      for (int b = 0; b < BANKS; b++)
      begin
         bank_wb_all[b]                      = 1'b0;
         bank_wb_id_all[b*P_DEPTH +: P_DEPTH] = '0;
         bank_wb_fls_all[b]                  = 1'b0;
         bank_wb_exc_all[b]                  = 1'b0;
         bank_wb_val_all[b*2*DW +: 2*DW]     = '0;
         for (int p = 0; p < WB; p++)
         begin
            // Only a valid port may claim a bank
            hit[b][p] = wb_valid[p] && (wb_rob_bank[p*P_BANKS +: P_BANKS] == P_BANKS'(b));
            if (hit[b][p])
            begin
               bank_wb_all[b]                      = 1'b1;
               bank_wb_id_all[b*P_DEPTH +: P_DEPTH] = wb_rob_id[p*P_DEPTH +: P_DEPTH];
               bank_wb_fls_all[b]                  = wb_fls[p];
               bank_wb_exc_all[b]                  = wb_exc[p];
               bank_wb_val_all[b*2*DW +: 2*DW]     = {wb_operb[p*DW +: DW],
                                                      wb_opera[p*DW +: DW]};
            end
         end
      end
   end

   // Two ports on one bank would lose a writeback
   for (genvar b = 0; b < BANKS; b++)
   begin : g_chk
      a_wb_collide: assert property (@(posedge clk) $onehot0(hit[b]));
   end

endmodule

/* src/rob_retire.sv */
// Commit side of the reorder buffer, head pointer, pop strobes and commit window
module rob_retire #(
   parameter int P_BANKS = 1,
   parameter int P_DEPTH = 2
) (
   input  logic                                       clk,
   input  logic                                       arst_n,
   input  logic                                       flush,
   input  logic [P_BANKS:0]                           cmt_pop_size,
   input  logic [(1<<P_BANKS)*rob_pkg::PAYLOAD_W-1:0] head_payload_all,
   input  logic [(1<<P_BANKS)-1:0]                    head_done_all,
   input  logic [(1<<P_BANKS)-1:0]                    head_fls_all,
   input  logic [(1<<P_BANKS)-1:0]                    head_exc_all,
   input  logic [(1<<P_BANKS)*2*rob_pkg::DW-1:0]      head_val_all,
   input  logic [(1<<P_BANKS)-1:0]                    bank_valid_all,
   output logic [(1<<P_BANKS)-1:0]                    bank_pop_all,
   output logic [(1<<P_BANKS)-1:0]                    cmt_valid,
   output logic [(1<<P_BANKS)*rob_pkg::PC_W-1:0]      cmt_pc,
   output logic [(1<<P_BANKS)*rob_pkg::LRF_AW-1:0]    cmt_lrd,
   output logic [(1<<P_BANKS)*rob_pkg::PRF_AW-1:0]    cmt_prd,
   output logic [(1<<P_BANKS)-1:0]                    cmt_prd_we,
   output logic [(1<<P_BANKS)*rob_pkg::PRF_AW-1:0]    cmt_pfree,
   output logic [(1<<P_BANKS)-1:0]                    cmt_fls,
   output logic [(1<<P_BANKS)-1:0]                    cmt_exc,
   output logic [(1<<P_BANKS)*rob_pkg::DW-1:0]        cmt_opera,
   output logic [(1<<P_BANKS)*rob_pkg::DW-1:0]        cmt_operb
);
   import rob_pkg::*;

   localparam int BANKS = 1 << P_BANKS;

   logic [P_BANKS-1:0] head_q;
   logic [P_BANKS:0]   lead_cnt;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         head_q <= '0;
      else if (flush)
         head_q <= '0;
      else
         head_q <= head_q + cmt_pop_size[P_BANKS-1:0];
   end

   for (genvar i = 0; i < BANKS; i++)
   begin : g_slot
      logic [P_BANKS-1:0] off;
      logic [P_BANKS-1:0] sel;

      // Bank i pops when it lies inside the retired group
      assign off = P_BANKS'(i) - head_q;
      assign bank_pop_all[i] = ({1'b0, off} < cmt_pop_size);

      // Slot i shows the bank i places past the head
      assign sel = head_q + P_BANKS'(i);
      assign cmt_valid[i] = bank_valid_all[sel] & head_done_all[sel];
      assign cmt_fls[i]   = head_fls_all[sel];
      assign cmt_exc[i]   = head_exc_all[sel];
      assign {cmt_pc[i*PC_W +: PC_W],
              cmt_lrd[i*LRF_AW +: LRF_AW],
              cmt_prd[i*PRF_AW +: PRF_AW],
              cmt_prd_we[i],
              cmt_pfree[i*PRF_AW +: PRF_AW]} = head_payload_all[sel*PAYLOAD_W +: PAYLOAD_W];
      assign {cmt_operb[i*DW +: DW],
              cmt_opera[i*DW +: DW]} = head_val_all[sel*2*DW +: 2*DW];
   end

   // Run of valid slots starting at slot 0
   always_comb
   begin
      lead_cnt = '0;
      for (int i = BANKS - 1; i >= 0; i--)
         lead_cnt = cmt_valid[i] ? lead_cnt + 1'b1 : '0;
   end

   a_pop_order: assert property (@(posedge clk) disable iff (!arst_n)
      cmt_pop_size <= lead_cnt);

endmodule

/* src/rob.sv */
// Banked reorder buffer top level wiring dispatch, writeback routing, banks and retire
module rob #(
   parameter int P_BANKS = 1,
   parameter int P_DEPTH = 2,
   parameter int P_WB    = 1
) (
   input  logic                                    clk,
   input  logic                                    arst_n,
   input  logic                                    flush,
   // Issue
   input  logic [P_BANKS:0]                        push_size,
   input  logic [(1<<P_BANKS)*rob_pkg::PC_W-1:0]    push_pc,
   input  logic [(1<<P_BANKS)*rob_pkg::LRF_AW-1:0]  push_lrd,
   input  logic [(1<<P_BANKS)*rob_pkg::PRF_AW-1:0]  push_prd,
   input  logic [(1<<P_BANKS)-1:0]                 push_prd_we,
   input  logic [(1<<P_BANKS)*rob_pkg::PRF_AW-1:0]  push_pfree,
   output logic                                    rob_ready,
   output logic [(1<<P_BANKS)*P_DEPTH-1:0]         rob_free_id,
   output logic [(1<<P_BANKS)*P_BANKS-1:0]         rob_free_bank,
   // Writeback
   input  logic [(1<<P_WB)-1:0]                    wb_valid,
   input  logic [(1<<P_WB)*P_BANKS-1:0]            wb_rob_bank,
   input  logic [(1<<P_WB)*P_DEPTH-1:0]            wb_rob_id,
   input  logic [(1<<P_WB)-1:0]                    wb_fls,
   input  logic [(1<<P_WB)-1:0]                    wb_exc,
   input  logic [(1<<P_WB)*rob_pkg::DW-1:0]        wb_opera,
   input  logic [(1<<P_WB)*rob_pkg::DW-1:0]        wb_operb,
   // Commit
   output logic [(1<<P_BANKS)-1:0]                 cmt_valid,
   output logic [(1<<P_BANKS)*rob_pkg::PC_W-1:0]    cmt_pc,
   output logic [(1<<P_BANKS)*rob_pkg::LRF_AW-1:0]  cmt_lrd,
   output logic [(1<<P_BANKS)*rob_pkg::PRF_AW-1:0]  cmt_prd,
   output logic [(1<<P_BANKS)-1:0]                 cmt_prd_we,
   output logic [(1<<P_BANKS)*rob_pkg::PRF_AW-1:0]  cmt_pfree,
   output logic [(1<<P_BANKS)-1:0]                 cmt_fls,
   output logic [(1<<P_BANKS)-1:0]                 cmt_exc,
   output logic [(1<<P_BANKS)*rob_pkg::DW-1:0]     cmt_opera,
   output logic [(1<<P_BANKS)*rob_pkg::DW-1:0]     cmt_operb,
   input  logic [P_BANKS:0]                        cmt_pop_size
);
   import rob_pkg::*;

   localparam int BANKS = 1 << P_BANKS;

   logic [BANKS-1:0]           bank_push_all;
   logic [BANKS*PAYLOAD_W-1:0] bank_din_all;
   logic [BANKS*P_DEPTH-1:0]   bank_wptr_all;
   logic [BANKS-1:0]           bank_ready_all;
   logic [BANKS-1:0]           bank_valid_all;
   logic [BANKS-1:0]           bank_pop_all;
   logic [BANKS-1:0]           bank_wb_all;
   logic [BANKS*P_DEPTH-1:0]   bank_wb_id_all;
   logic [BANKS-1:0]           bank_wb_fls_all;
   logic [BANKS-1:0]           bank_wb_exc_all;
   logic [BANKS*2*DW-1:0]      bank_wb_val_all;
   logic [BANKS*PAYLOAD_W-1:0] head_payload_all;
   logic [BANKS-1:0]           head_done_all;
   logic [BANKS-1:0]           head_fls_all;
   logic [BANKS-1:0]           head_exc_all;
   logic [BANKS*2*DW-1:0]      head_val_all;

   rob_dispatch #(.P_BANKS(P_BANKS), .P_DEPTH(P_DEPTH)) dispatch_i (
      .clk            (clk),
      .arst_n         (arst_n),
      .flush          (flush),
      .push_size      (push_size),
      .push_pc        (push_pc),
      .push_lrd       (push_lrd),
      .push_prd       (push_prd),
      .push_prd_we    (push_prd_we),
      .push_pfree     (push_pfree),
      .bank_wptr_all  (bank_wptr_all),
      .bank_ready_all (bank_ready_all),
      .rob_ready      (rob_ready),
      .rob_free_id    (rob_free_id),
      .rob_free_bank  (rob_free_bank),
      .bank_push_all  (bank_push_all),
      .bank_din_all   (bank_din_all)
   );

   rob_wb_route #(.P_BANKS(P_BANKS), .P_DEPTH(P_DEPTH), .P_WB(P_WB)) wb_route_i (
      .clk             (clk),
      .wb_valid        (wb_valid),
      .wb_rob_bank     (wb_rob_bank),
      .wb_rob_id       (wb_rob_id),
      .wb_fls          (wb_fls),
      .wb_exc          (wb_exc),
      .wb_opera        (wb_opera),
      .wb_operb        (wb_operb),
      .bank_wb_all     (bank_wb_all),
      .bank_wb_id_all  (bank_wb_id_all),
      .bank_wb_fls_all (bank_wb_fls_all),
      .bank_wb_exc_all (bank_wb_exc_all),
      .bank_wb_val_all (bank_wb_val_all)
   );

   for (genvar b = 0; b < BANKS; b++)
   begin : g_bank
      rob_bank #(.P_DEPTH(P_DEPTH)) bank_i (
         .clk          (clk),
         .arst_n       (arst_n),
         .flush        (flush),
         .bank_push    (bank_push_all[b]),
         .bank_din     (bank_din_all[b*PAYLOAD_W +: PAYLOAD_W]),
         .bank_pop     (bank_pop_all[b]),
         .bank_wb      (bank_wb_all[b]),
         .bank_wb_id   (bank_wb_id_all[b*P_DEPTH +: P_DEPTH]),
         .bank_wb_fls  (bank_wb_fls_all[b]),
         .bank_wb_exc  (bank_wb_exc_all[b]),
         .bank_wb_val  (bank_wb_val_all[b*2*DW +: 2*DW]),
         .bank_valid   (bank_valid_all[b]),
         .bank_ready   (bank_ready_all[b]),
         .bank_wptr    (bank_wptr_all[b*P_DEPTH +: P_DEPTH]),
         .head_payload (head_payload_all[b*PAYLOAD_W +: PAYLOAD_W]),
         .head_done    (head_done_all[b]),
         .head_fls     (head_fls_all[b]),
         .head_exc     (head_exc_all[b]),
         .head_val     (head_val_all[b*2*DW +: 2*DW])
      );
   end

   rob_retire #(.P_BANKS(P_BANKS), .P_DEPTH(P_DEPTH)) retire_i (
      .clk              (clk),
      .arst_n           (arst_n),
      .flush            (flush),
      .cmt_pop_size     (cmt_pop_size),
      .head_payload_all (head_payload_all),
      .head_done_all    (head_done_all),
      .head_fls_all     (head_fls_all),
      .head_exc_all     (head_exc_all),
      .head_val_all     (head_val_all),
      .bank_valid_all   (bank_valid_all),
      .bank_pop_all     (bank_pop_all),
      .cmt_valid        (cmt_valid),
      .cmt_pc           (cmt_pc),
      .cmt_lrd          (cmt_lrd),
      .cmt_prd          (cmt_prd),
      .cmt_prd_we       (cmt_prd_we),
      .cmt_pfree        (cmt_pfree),
      .cmt_fls          (cmt_fls),
      .cmt_exc          (cmt_exc),
      .cmt_opera        (cmt_opera),
      .cmt_operb        (cmt_operb)
   );

endmodule

/* verif/rob_tb.sv */
// Testbench for the banked reorder buffer checking a cycle table against a queue model
module rob_tb;
   timeunit 1ns;
   timeprecision 100ps;
   import rob_pkg::*;

   localparam int P_BANKS    = 1;
   localparam int P_DEPTH    = 2;
   localparam int P_WB       = 1;
   localparam int BANKS      = 1 << P_BANKS;
   localparam int DEPTH      = 1 << P_DEPTH;
   localparam int WB         = 1 << P_WB;
   localparam int NROWS      = 30;
   localparam int MAX_CYCLES = 100;

   typedef struct packed {
      logic                 done;
      logic                 fls;
      logic                 exc;
      logic [P_BANKS-1:0]   bank;
      logic [P_DEPTH-1:0]   id;
      logic [2*DW-1:0]      val;
      logic [PAYLOAD_W-1:0] payload;
   } entry_t;

   logic                       clk;
   logic                       arst_n;
   logic                       flush;
   logic                       rob_ready;
   logic [P_BANKS:0]           push_size;
   logic [P_BANKS:0]           cmt_pop_size;
   logic [BANKS*PC_W-1:0]      push_pc;
   logic [BANKS*PC_W-1:0]      cmt_pc;
   logic [BANKS*LRF_AW-1:0]    push_lrd;
   logic [BANKS*LRF_AW-1:0]    cmt_lrd;
   logic [BANKS*PRF_AW-1:0]    push_prd;
   logic [BANKS*PRF_AW-1:0]    push_pfree;
   logic [BANKS*PRF_AW-1:0]    cmt_prd;
   logic [BANKS*PRF_AW-1:0]    cmt_pfree;
   logic [BANKS-1:0]           push_prd_we;
   logic [BANKS-1:0]           cmt_prd_we;
   logic [BANKS-1:0]           cmt_valid;
   logic [BANKS-1:0]           cmt_fls;
   logic [BANKS-1:0]           cmt_exc;
   logic [BANKS*P_DEPTH-1:0]   rob_free_id;
   logic [BANKS*P_BANKS-1:0]   rob_free_bank;
   logic [WB-1:0]              wb_valid;
   logic [WB-1:0]              wb_fls;
   logic [WB-1:0]              wb_exc;
   logic [WB*P_BANKS-1:0]      wb_rob_bank;
   logic [WB*P_DEPTH-1:0]      wb_rob_id;
   logic [WB*DW-1:0]           wb_opera;
   logic [WB*DW-1:0]           wb_operb;
   logic [BANKS*DW-1:0]        cmt_opera;
   logic [BANKS*DW-1:0]        cmt_operb;

   // Reference model state
   integer               seed;
   logic [P_BANKS-1:0]   m_tail;
   logic [P_BANKS-1:0]   m_head;
   logic [P_DEPTH-1:0]   m_wptr [BANKS];
   entry_t               q [$];
   int                   pend_idx [WB];
   logic [PAYLOAD_W-1:0] pend_payload [BANKS];
   logic [2*DW-1:0]      pend_val [WB];

   // Nibbles from the top are push pop flush wb_valid wb0_off wb1_off wb_fls wb_exc
   // Offsets count entries from the oldest one in program order
   logic [31:0] table_rows [NROWS] = '{
      32'h0000_0000, 32'h2000_0000, 32'h1000_0000, 32'h2000_0000,
      // Younger entry completes first
      32'h0001_1010, 32'h0003_0301, 32'h0000_0000,
      // Pops of one and two across pointer wrap
      32'h0101_2000, 32'h0200_0000, 32'h2001_1000, 32'h0200_0000,
      32'h2000_0000, 32'h0003_0120, 32'h0200_0000,
      // Fill both banks, then drain one entry at a time
      32'h2000_0000, 32'h2000_0000, 32'h2000_0000, 32'h0000_0000,
      32'h0003_0100, 32'h0100_0000, 32'h0100_0000, 32'h1000_0000,
      32'h0003_0103, 32'h0100_0000,
      // Flush with a push and a writeback that must vanish
      32'h2011_0000, 32'h0000_0000, 32'h2000_0000, 32'h0003_0132,
      32'h0200_0000, 32'h0000_0000
   };

   rob dut_i (.*);

   initial
   begin
      clk = 1'b0;
      forever
         #20 clk = ~clk;
   end

   initial
   begin
      repeat (MAX_CYCLES) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      abort_run();
   end

   task automatic abort_run();
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
      assert (got === exp)
      else
      begin
         $display("Error: %s is 0x%0h, expected 0x%0h", name, got, exp);
         abort_run();
      end
   endtask

   task automatic check_rule(input logic cond, input string what);
      assert (cond)
      else
      begin
         $display("Stimulus error: %s", what);
         abort_run();
      end
   endtask

   function automatic int bank_fill(input int b);
      int n;
      n = 0;
      foreach (q[k])
         if (int'(q[k].bank) == b)
            n++;
      return n;
   endfunction

   // Index of the oldest entry held in a bank or -1 if none
   function automatic int oldest_in(input int b);
      foreach (q[k])
         if (int'(q[k].bank) == b)
            return k;
      return -1;
   endfunction

   function automatic logic model_ready();
      for (int b = 0; b < BANKS; b++)
         if (bank_fill(b) == DEPTH)
            return 1'b0;
      return 1'b1;
   endfunction

   function automatic int lead_done();
      int n;
      n = 0;
      while (n < q.size() && q[n].done)
         n++;
      return n;
   endfunction

   // Apply what the DUT sampled at this edge
   task automatic step_model();
      entry_t e;
      if (flush)
      begin
         q.delete();
         m_tail = '0;
         m_head = '0;
         foreach (m_wptr[b])
            m_wptr[b] = '0;
      end
      else
      begin
         for (int p = 0; p < WB; p++)
         begin
            if (wb_valid[p])
            begin
               e = q[pend_idx[p]];
               e.done = 1'b1;
               e.fls  = wb_fls[p];
               e.exc  = wb_exc[p];
               e.val  = pend_val[p];
               q[pend_idx[p]] = e;
            end
         end
         for (int k = 0; k < int'(cmt_pop_size); k++)
            q.delete(oldest_in((int'(m_head) + k) % BANKS));
         m_head = P_BANKS'((int'(m_head) + int'(cmt_pop_size)) % BANKS);
         for (int i = 0; i < int'(push_size); i++)
         begin
            e = '0;
            e.bank    = P_BANKS'((int'(m_tail) + i) % BANKS);
            e.id      = m_wptr[e.bank];
            e.payload = pend_payload[i];
            q.push_back(e);
            m_wptr[e.bank] = P_DEPTH'((int'(m_wptr[e.bank]) + 1) % DEPTH);
         end
         m_tail = P_BANKS'((int'(m_tail) + int'(push_size)) % BANKS);
      end
   endtask

   task automatic load_row(input logic [31:0] row);
      entry_t                e;
      int                    off [WB];
      logic [WB*P_BANKS-1:0] wbank;
      logic [WB*P_DEPTH-1:0] wid;
      logic [BANKS*PC_W-1:0] pc;
      logic [BANKS*LRF_AW-1:0] lrd;
      logic [BANKS*PRF_AW-1:0] prd;
      logic [BANKS*PRF_AW-1:0] pfree;
      logic [BANKS-1:0]      we;
      logic [WB*DW-1:0]      opa;
      logic [WB*DW-1:0]      opb;
      wbank = '0;
      wid   = '0;
      check_rule(row[31:28] == 4'h0 || model_ready(), "table pushes while a bank is full");
      check_rule(int'(row[27:24]) <= lead_done(), "table pops an entry that has not completed");
      for (int p = 0; p < WB; p++)
      begin
         off[p] = int'(row[12 - 4 * p +: 4]);
         if (row[16 + p])
         begin
            check_rule(off[p] < q.size(), "table writes back an entry that is not pushed");
            e = q[off[p]];
            pend_idx[p] = off[p];
            wbank[p*P_BANKS +: P_BANKS] = e.bank;
            wid[p*P_DEPTH +: P_DEPTH]   = e.id;
         end
         opa[p*DW +: DW] = DW'($random(seed));
         opb[p*DW +: DW] = DW'($random(seed));
         pend_val[p] = {opb[p*DW +: DW], opa[p*DW +: DW]};
      end
      check_rule(row[17:16] != 2'b11 || wbank[0 +: P_BANKS] != wbank[P_BANKS +: P_BANKS],
                 "two writeback ports name the same bank");
      for (int i = 0; i < BANKS; i++)
      begin
         pc[i*PC_W +: PC_W]        = PC_W'($random(seed));
         lrd[i*LRF_AW +: LRF_AW]   = LRF_AW'($random(seed));
         prd[i*PRF_AW +: PRF_AW]   = PRF_AW'($random(seed));
         pfree[i*PRF_AW +: PRF_AW] = PRF_AW'($random(seed));
         we[i]                     = 1'($random(seed));
         pend_payload[i] = {pc[i*PC_W +: PC_W], lrd[i*LRF_AW +: LRF_AW],
                            prd[i*PRF_AW +: PRF_AW], we[i], pfree[i*PRF_AW +: PRF_AW]};
      end
      push_size    <= row[28 +: P_BANKS+1];
      cmt_pop_size <= row[24 +: P_BANKS+1];
      flush        <= row[20];
      wb_valid     <= row[16 +: WB];
      wb_rob_bank  <= wbank;
      wb_rob_id    <= wid;
      wb_fls       <= row[4 +: WB];
      wb_exc       <= row[0 +: WB];
      wb_opera     <= opa;
      wb_operb     <= opb;
      push_pc      <= pc;
      push_lrd     <= lrd;
      push_prd     <= prd;
      push_prd_we  <= we;
      push_pfree   <= pfree;
   endtask

   task automatic check_outputs();
      entry_t             e;
      int                 k;
      logic [P_BANKS-1:0] fbank;
      check_val("rob_ready", 64'(rob_ready), 64'(model_ready()));
      for (int i = 0; i < BANKS; i++)
      begin
         fbank = P_BANKS'((int'(m_tail) + i) % BANKS);
         check_val($sformatf("rob_free_bank[%0d]", i),
                   64'(rob_free_bank[i*P_BANKS +: P_BANKS]), 64'(fbank));
         check_val($sformatf("rob_free_id[%0d]", i),
                   64'(rob_free_id[i*P_DEPTH +: P_DEPTH]), 64'(m_wptr[fbank]));
         // Slot i shows the bank i places past the head
         k = oldest_in((int'(m_head) + i) % BANKS);
         if (k < 0)
            check_val($sformatf("cmt_valid[%0d]", i), 64'(cmt_valid[i]), 64'(0));
         else
         begin
            e = q[k];
            check_val($sformatf("cmt_valid[%0d]", i), 64'(cmt_valid[i]), 64'(e.done));
            check_val($sformatf("cmt_pc[%0d]", i), 64'(cmt_pc[i*PC_W +: PC_W]),
                      64'(e.payload[PAYLOAD_W-1 -: PC_W]));
            check_val($sformatf("cmt_lrd[%0d]", i), 64'(cmt_lrd[i*LRF_AW +: LRF_AW]),
                      64'(e.payload[PAYLOAD_W-PC_W-1 -: LRF_AW]));
            check_val($sformatf("cmt_prd[%0d]", i), 64'(cmt_prd[i*PRF_AW +: PRF_AW]),
                      64'(e.payload[2*PRF_AW -: PRF_AW]));
            check_val($sformatf("cmt_prd_we[%0d]", i), 64'(cmt_prd_we[i]),
                      64'(e.payload[PRF_AW]));
            check_val($sformatf("cmt_pfree[%0d]", i), 64'(cmt_pfree[i*PRF_AW +: PRF_AW]),
                      64'(e.payload[PRF_AW-1:0]));
            check_val($sformatf("cmt_fls[%0d]", i), 64'(cmt_fls[i]), 64'(e.fls));
            check_val($sformatf("cmt_exc[%0d]", i), 64'(cmt_exc[i]), 64'(e.exc));
            if (e.done)
            begin
               check_val($sformatf("cmt_opera[%0d]", i), 64'(cmt_opera[i*DW +: DW]),
                         64'(e.val[DW-1:0]));
               check_val($sformatf("cmt_operb[%0d]", i), 64'(cmt_operb[i*DW +: DW]),
                         64'(e.val[2*DW-1:DW]));
            end
         end
      end
   endtask

   initial
   begin
      seed         = 32'h1da3;
      arst_n       = 1'b0;
      flush        = 1'b0;
      push_size    = '0;
      cmt_pop_size = '0;
      push_pc      = '0;
      push_lrd     = '0;
      push_prd     = '0;
      push_prd_we  = '0;
      push_pfree   = '0;
      wb_valid     = '0;
      wb_rob_bank  = '0;
      wb_rob_id    = '0;
      wb_fls       = '0;
      wb_exc       = '0;
      wb_opera     = '0;
      wb_operb     = '0;
      m_tail       = '0;
      m_head       = '0;
      foreach (m_wptr[b])
         m_wptr[b] = '0;
      repeat (8) @(posedge clk);
      arst_n <= 1'b1;
      // One row per cycle, outputs checked at the falling edge
      foreach (table_rows[r])
      begin
         @(posedge clk);
         step_model();
         load_row(table_rows[r]);
         @(negedge clk);
         check_outputs();
      end
      @(posedge clk);
      step_model();
      load_row('0);
      @(negedge clk);
      check_outputs();
      $display("TEST OK");
      $finish;
   end

endmodule

/* list.f */
src/rob_pkg.sv
src/rob_bank.sv
src/rob_dispatch.sv
src/rob_wb_route.sv
src/rob_retire.sv
src/rob.sv
verif/rob_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --timing --assert --timescale 1ns/100ps
TOP       = rob_tb
FLIST     = list.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = TEST FAILED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FLIST)

build:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation reported a failure"; exit 1; fi
	@grep -q "TEST OK" $(LOG) || (echo "No pass line in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
